//--- icache_pkg.sv
package icache_pkg;

	// instruction word or byte address
	typedef logic [31:0] word_t;

	// refill controller states
	typedef enum logic [2:0] {
		SWEEP,     // invalidate all tags after reset
		IDLE,
		REQUEST,   // waiting for grant
		RECEIVING, // burst beats arriving
		REFILL     // tag write
	} refill_state_t;

endpackage

//--- icache_tag_ram.sv
`timescale 1ns/1ps

module icache_tag_ram #(
	parameter int SETS = 16,
	parameter int WORDS_PER_LINE = 8,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_LINE),
	localparam int TAG_W = 30 - OFF_W - IDX_W
) (
	input  logic             i_clk,
	input  logic [IDX_W-1:0] i_raddr,
	output logic             o_rvalid,
	output logic [TAG_W-1:0] o_rtag,
	input  logic             i_wen,
	input  logic [IDX_W-1:0] i_waddr,
	input  logic             i_wvalid,
	input  logic [TAG_W-1:0] i_wtag
);

	logic [TAG_W:0] mem [SETS]; // {valid, tag}

	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			mem[i_waddr] <= {i_wvalid, i_wtag};
		end
		{o_rvalid, o_rtag} <= mem[i_raddr];
	end

endmodule

//--- icache_data_ram.sv
`timescale 1ns/1ps

module icache_data_ram #(
	parameter int SETS = 16,
	parameter int WORDS_PER_LINE = 8,
	localparam int ADDR_W = $clog2(SETS) + $clog2(WORDS_PER_LINE)
) (
	input  logic                i_clk,
	input  logic [ADDR_W-1:0]   i_raddr, // {index, word offset}
	output icache_pkg::word_t   o_rdata,
	input  logic                i_wen,
	input  logic [ADDR_W-1:0]   i_waddr,
	input  icache_pkg::word_t   i_wdata
);

	import icache_pkg::*;

	word_t mem [SETS*WORDS_PER_LINE];

	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
		o_rdata <= mem[i_raddr]; // old data on same-address write
	end

endmodule

//--- icache_plru.sv
`timescale 1ns/1ps

module icache_plru #(
	parameter int WAYS = 4,
	parameter int SETS = 16,
	localparam int WAY_W = $clog2(WAYS),
	localparam int IDX_W = $clog2(SETS)
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_use,
	input  logic [IDX_W-1:0] i_use_index,
	input  logic [WAY_W-1:0] i_use_way,
	input  logic [IDX_W-1:0] i_victim_index,
	output logic [WAY_W-1:0] o_victim_way
);

	// heap order with children 2n+1 (low half) and 2n+2 (high half) under node n
	logic [WAYS-2:0] r_tree [SETS];
	logic [WAYS-2:0] w_tree_next;

	// follow the bits down to the colder leaf
	always_comb begin
		int node;
		node = 0;
		o_victim_way = '0;
		for (int l = 0; l < WAY_W; l++) begin
			o_victim_way[WAY_W-1-l] = r_tree[i_victim_index][node];
			node = 2*node + 1 + int'(r_tree[i_victim_index][node]);
		end
	end

	always_comb begin
		int node;
		node = 0;
		w_tree_next = r_tree[i_use_index];
		for (int l = 0; l < WAY_W; l++) begin
			w_tree_next[node] = ~i_use_way[WAY_W-1-l]; // point away from used half
			node = 2*node + 1 + int'(i_use_way[WAY_W-1-l]);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < SETS; s++) begin
				r_tree[s] <= '0;
			end
		end else if (i_use) begin
			r_tree[i_use_index] <= w_tree_next;
		end
	end

endmodule

//--- icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup #(
	parameter int WAYS = 4,
	parameter int SETS = 16,
	parameter int WORDS_PER_LINE = 8,
	localparam int WAY_W = $clog2(WAYS),
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_LINE),
	localparam int TAG_W = 30 - OFF_W - IDX_W
) (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_req_valid,
	input  icache_pkg::word_t      i_va,
	input  icache_pkg::word_t      i_pa,
	input  logic                   i_accept, // cache ready this cycle
	output logic                   o_hit,
	output logic                   o_miss,
	output logic [WAY_W-1:0]       o_hit_way,
	output icache_pkg::word_t      o_data,
	output logic [IDX_W-1:0]       o_index,
	output icache_pkg::word_t      o_pa,
	input  logic                   i_tag_wen,
	input  logic [WAY_W-1:0]       i_tag_way,
	input  logic [IDX_W-1:0]       i_tag_index,
	input  logic                   i_tag_valid,
	input  logic [TAG_W-1:0]       i_tag_value,
	input  logic                   i_data_wen,
	input  logic [WAY_W-1:0]       i_data_way,
	input  logic [IDX_W+OFF_W-1:0] i_data_addr,
	input  icache_pkg::word_t      i_data_word
);

	import icache_pkg::*;

	localparam int TAG_LO = 2 + OFF_W + IDX_W;

	logic             r_valid;
	logic [IDX_W-1:0] r_index;
	logic [OFF_W-1:0] r_offset;
	logic [IDX_W-1:0] w_index;
	logic [OFF_W-1:0] w_offset;
	logic [WAYS-1:0]  w_tvalid;
	logic [TAG_W-1:0] w_rtag [WAYS];
	word_t            w_rdata [WAYS];
	logic [WAYS-1:0]  w_way_hit;

	assign w_index = i_va[TAG_LO-1:2+OFF_W];
	assign w_offset = i_va[2+OFF_W-1:2];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= i_req_valid && i_accept;
		end
	end

	always_ff @(posedge i_clk) begin
		r_index <= w_index;
		r_offset <= w_offset;
	end

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		icache_tag_ram #(
			.SETS(SETS),
			.WORDS_PER_LINE(WORDS_PER_LINE)
		) tag_i (
			.i_clk,
			.i_raddr(w_index),
			.o_rvalid(w_tvalid[w]),
			.o_rtag(w_rtag[w]),
			// invalidate writes every way of the set
			.i_wen(i_tag_wen && (!i_tag_valid || i_tag_way == WAY_W'(w))),
			.i_waddr(i_tag_index),
			.i_wvalid(i_tag_valid),
			.i_wtag(i_tag_value)
		);

		icache_data_ram #(
			.SETS(SETS),
			.WORDS_PER_LINE(WORDS_PER_LINE)
		) data_i (
			.i_clk,
			.i_raddr({w_index, w_offset}),
			.o_rdata(w_rdata[w]),
			.i_wen(i_data_wen && i_data_way == WAY_W'(w)),
			.i_waddr(i_data_addr),
			.i_wdata(i_data_word)
		);

		assign w_way_hit[w] = w_tvalid[w] && (w_rtag[w] == i_pa[31:TAG_LO]);
	end

	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (w_way_hit[w]) begin
				o_hit_way = WAY_W'(w);
			end
		end
	end

	assign o_hit = r_valid && (|w_way_hit);
	assign o_miss = r_valid && !(|w_way_hit);
	assign o_data = w_rdata[o_hit_way];
	assign o_index = r_index;
	// physical tag over the untranslated low bits of the va stage
	assign o_pa = {i_pa[31:TAG_LO], r_index, r_offset, 2'b00};

endmodule

//--- icache_refill.sv
`timescale 1ns/1ps

module icache_refill #(
	parameter int SETS = 16,
	parameter int WORDS_PER_LINE = 8,
	parameter int WAYS = 4,
	localparam int WAY_W = $clog2(WAYS),
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_LINE),
	localparam int TAG_W = 30 - OFF_W - IDX_W
) (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_miss,
	input  icache_pkg::word_t      i_pa,
	input  logic [IDX_W-1:0]       i_index,
	input  logic [WAY_W-1:0]       i_victim_way,
	output logic                   o_ready_state,
	output logic                   o_mem_req,
	output icache_pkg::word_t      o_mem_addr,
	input  logic                   i_mem_gnt,
	input  logic                   i_mem_valid,
	input  icache_pkg::word_t      i_mem_data,
	input  logic                   i_mem_last,
	output logic                   o_restart_valid,
	output icache_pkg::word_t      o_restart_data,
	output logic                   o_tag_wen,
	output logic [WAY_W-1:0]       o_tag_way,
	output logic [IDX_W-1:0]       o_tag_index,
	output logic                   o_tag_valid,
	output logic [TAG_W-1:0]       o_tag_value,
	output logic                   o_data_wen,
	output logic [WAY_W-1:0]       o_data_way,
	output logic [IDX_W+OFF_W-1:0] o_data_addr,
	output icache_pkg::word_t      o_data_word
);

	import icache_pkg::*;

	localparam int TAG_LO = 2 + OFF_W + IDX_W;

	refill_state_t    r_state;
	refill_state_t    w_state_next;
	logic [IDX_W-1:0] r_sweep_idx;
	word_t            r_addr; // word address of the missed word
	logic [IDX_W-1:0] r_index;
	logic [WAY_W-1:0] r_way;
	logic [OFF_W-1:0] r_beat_off;
	logic [OFF_W-1:0] w_miss_off;
	logic             w_beat;

	assign w_miss_off = r_addr[2+OFF_W-1:2];
	assign w_beat = (r_state == RECEIVING) && i_mem_valid;

	always_comb begin
		w_state_next = r_state;
		case (r_state)
			SWEEP: if (&r_sweep_idx) w_state_next = IDLE;
			IDLE: if (i_miss) w_state_next = REQUEST;
			REQUEST: if (i_mem_gnt) w_state_next = RECEIVING;
			RECEIVING: if (w_beat && i_mem_last) w_state_next = REFILL;
			REFILL: w_state_next = IDLE;
			default: w_state_next = SWEEP;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= SWEEP;
			r_sweep_idx <= '0;
		end else begin
			r_state <= w_state_next;
			if (r_state == SWEEP) begin
				r_sweep_idx <= r_sweep_idx + 1'b1;
			end
		end
	end

	// miss capture, then the wrapping beat offset
	always_ff @(posedge i_clk) begin
		if (r_state == IDLE && i_miss) begin
			r_addr <= {i_pa[31:2], 2'b00};
			r_index <= i_index;
			r_way <= i_victim_way;
			r_beat_off <= i_pa[2+OFF_W-1:2]; // burst starts at missed word
		end else if (w_beat) begin
			r_beat_off <= r_beat_off + 1'b1;
		end
	end

	assign o_ready_state = (r_state == IDLE);
	assign o_mem_req = (r_state == REQUEST);
	assign o_mem_addr = r_addr;

	// early restart
	assign o_restart_valid = w_beat && (r_beat_off == w_miss_off);
	assign o_restart_data = i_mem_data;

	assign o_tag_wen = (r_state == SWEEP) || (r_state == REFILL);
	assign o_tag_way = r_way;
	assign o_tag_index = (r_state == SWEEP) ? r_sweep_idx : r_index;
	assign o_tag_valid = (r_state == REFILL);
	assign o_tag_value = r_addr[31:TAG_LO];

	assign o_data_wen = w_beat;
	assign o_data_way = r_way;
	assign o_data_addr = {r_index, r_beat_off};
	assign o_data_word = i_mem_data;

endmodule

//--- icache.sv
`timescale 1ns/1ps

module icache #(
	parameter int WAYS = 4,
	parameter int SETS = 16,
	parameter int WORDS_PER_LINE = 8,
	localparam int WAY_W = $clog2(WAYS),
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_LINE),
	localparam int TAG_W = 30 - OFF_W - IDX_W
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_req_valid,
	input  icache_pkg::word_t i_va,
	input  icache_pkg::word_t i_pa, // one cycle after i_va
	output logic              o_ready,
	output logic              o_valid,
	output icache_pkg::word_t o_data,
	output logic              o_mem_req,
	output icache_pkg::word_t o_mem_addr,
	input  logic              i_mem_gnt,
	input  logic              i_mem_valid,
	input  icache_pkg::word_t i_mem_data,
	input  logic              i_mem_last
);

	import icache_pkg::*;

	logic                   w_hit;
	logic                   w_miss;
	logic [WAY_W-1:0]       w_hit_way;
	word_t                  w_hit_data;
	logic [IDX_W-1:0]       w_index;
	word_t                  w_pa;
	logic                   w_ready_state;
	logic                   w_restart_valid;
	word_t                  w_restart_data;
	logic [WAY_W-1:0]       w_victim_way;
	logic                   w_tag_wen;
	logic [WAY_W-1:0]       w_tag_way;
	logic [IDX_W-1:0]       w_tag_index;
	logic                   w_tag_valid;
	logic [TAG_W-1:0]       w_tag_value;
	logic                   w_data_wen;
	logic [WAY_W-1:0]       w_data_way;
	logic [IDX_W+OFF_W-1:0] w_data_addr;
	word_t                  w_data_word;
	logic                   w_fill;

	// a miss in compare holds off the request behind it
	assign o_ready = w_ready_state && !w_miss;
	assign o_valid = w_hit || w_restart_valid;
	assign o_data = w_restart_valid ? w_restart_data : w_hit_data;
	assign w_fill = w_tag_wen && w_tag_valid; // new line installed

	icache_lookup #(
		.WAYS(WAYS),
		.SETS(SETS),
		.WORDS_PER_LINE(WORDS_PER_LINE)
	) lookup_i (
		.i_clk,
		.i_rst,
		.i_req_valid,
		.i_va,
		.i_pa,
		.i_accept(o_ready),
		.o_hit(w_hit),
		.o_miss(w_miss),
		.o_hit_way(w_hit_way),
		.o_data(w_hit_data),
		.o_index(w_index),
		.o_pa(w_pa),
		.i_tag_wen(w_tag_wen),
		.i_tag_way(w_tag_way),
		.i_tag_index(w_tag_index),
		.i_tag_valid(w_tag_valid),
		.i_tag_value(w_tag_value),
		.i_data_wen(w_data_wen),
		.i_data_way(w_data_way),
		.i_data_addr(w_data_addr),
		.i_data_word(w_data_word)
	);

	icache_refill #(
		.SETS(SETS),
		.WORDS_PER_LINE(WORDS_PER_LINE),
		.WAYS(WAYS)
	) refill_i (
		.i_clk,
		.i_rst,
		.i_miss(w_miss),
		.i_pa(w_pa),
		.i_index(w_index),
		.i_victim_way(w_victim_way),
		.o_ready_state(w_ready_state),
		.o_mem_req,
		.o_mem_addr,
		.i_mem_gnt,
		.i_mem_valid,
		.i_mem_data,
		.i_mem_last,
		.o_restart_valid(w_restart_valid),
		.o_restart_data(w_restart_data),
		.o_tag_wen(w_tag_wen),
		.o_tag_way(w_tag_way),
		.o_tag_index(w_tag_index),
		.o_tag_valid(w_tag_valid),
		.o_tag_value(w_tag_value),
		.o_data_wen(w_data_wen),
		.o_data_way(w_data_way),
		.o_data_addr(w_data_addr),
		.o_data_word(w_data_word)
	);

	icache_plru #(
		.WAYS(WAYS),
		.SETS(SETS)
	) plru_i (
		.i_clk,
		.i_rst,
		.i_use(w_hit || w_fill),
		.i_use_index(w_hit ? w_index : w_tag_index),
		.i_use_way(w_hit ? w_hit_way : w_tag_way),
		.i_victim_index(w_index),
		.o_victim_way(w_victim_way)
	);

endmodule

//--- icache_assert.sv
`timescale 1ns/1ps

module icache_assert (
	input logic                      i_clk,
	input logic                      i_rst,
	input icache_pkg::refill_state_t i_state,
	input logic                      i_valid,
	input logic                      i_mem_req,
	input icache_pkg::word_t         i_mem_addr,
	input logic                      i_mem_gnt
);

	import icache_pkg::*;

	// request stays up until granted
	a_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_req && !i_mem_gnt |=> i_mem_req)
		else $error("memory request dropped before its grant");

	a_addr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_req && !i_mem_gnt |=> $stable(i_mem_addr))
		else $error("memory address changed while the request was pending");

	a_quiet_sweep: assert property (@(posedge i_clk) disable iff (i_rst)
		i_state == SWEEP |-> !i_valid)
		else $error("fetch data valid during the tag sweep");

endmodule

//--- tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

	import icache_pkg::*;

	localparam int WAYS = 4;
	localparam int SETS = 16;
	localparam int WORDS = 8;
	localparam int LINE_BYTES = WORDS * 4;
	localparam int TIMEOUT = 4000; // sweep plus about forty refills with gaps

	logic        i_clk = 1'b0;
	logic        i_rst;
	logic        i_req_valid;
	word_t       i_va;
	word_t       i_pa;
	logic        o_ready;
	logic        o_valid;
	word_t       o_data;
	logic        o_mem_req;
	word_t       o_mem_addr;
	logic        i_mem_gnt;
	logic        i_mem_valid;
	word_t       i_mem_data;
	logic        i_mem_last;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          mem_reqs = 0;
	word_t       last_mem_addr = '0;
	logic [31:0] rng = 32'hfe8b_6160;

	icache #(
		.WAYS(WAYS),
		.SETS(SETS),
		.WORDS_PER_LINE(WORDS)
	) icache_i (.*);

	bind icache icache_assert assert_i (
		.i_clk,
		.i_rst,
		.i_state(refill_i.r_state),
		.i_valid(o_valid),
		.i_mem_req(o_mem_req),
		.i_mem_addr(o_mem_addr),
		.i_mem_gnt
	);

	always #10 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("checks %0d, errors %0d", checks, errors);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t translate(input word_t va);
		return {4'h8, va[27:0]};
	endfunction

	// memory contents rule
	function automatic word_t mem_word(input word_t addr);
		return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	// beat k of a burst wraps inside the line
	function automatic word_t beat_addr(input word_t miss_addr, input int k);
		word_t line;
		int    off;
		line = miss_addr & ~word_t'(LINE_BYTES - 1);
		off = (int'(miss_addr[4:2]) + k) % WORDS;
		return line + word_t'(off * 4);
	endfunction

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge i_clk);
		#1;
	endtask

	// memory model with random grant delay and random gaps between beats
	initial begin
		int delay;
		int gap;
		i_mem_gnt = 1'b0;
		i_mem_valid = 1'b0;
		i_mem_data = '0;
		i_mem_last = 1'b0;
		forever begin
			@(negedge i_clk);
			if (o_mem_req) begin
				mem_reqs++;
				last_mem_addr = o_mem_addr;
				rng = xorshift(rng);
				delay = int'(rng % 4);
				next_cycle();
				repeat (delay) next_cycle();
				i_mem_gnt = 1'b1;
				next_cycle();
				i_mem_gnt = 1'b0;
				for (int k = 0; k < WORDS; k++) begin
					rng = xorshift(rng);
					gap = int'(rng % 3);
					repeat (gap) next_cycle();
					i_mem_valid = 1'b1;
					i_mem_data = mem_word(beat_addr(last_mem_addr, k));
					i_mem_last = (k == WORDS - 1);
					next_cycle();
					i_mem_valid = 1'b0;
					i_mem_last = 1'b0;
				end
			end
		end
	end

	// issues requests in order and drives pa one cycle after acceptance
	task automatic run_fetches(input string name, input word_t vas[$], input logic all_hit);
		word_t exp_q[$];
		word_t last_pa;
		int    issued;
		int    done;
		logic  cmp;
		issued = 0;
		done = 0;
		cmp = 1'b0;
		last_pa = '0;
		while (done < vas.size()) begin
			i_req_valid = (issued < vas.size());
			i_va = (issued < vas.size()) ? vas[issued] : '0;
			i_pa = last_pa;
			@(negedge i_clk);
			if (all_hit && cmp && !o_valid) begin
				$display("ERROR %s: no o_valid one cycle after acceptance", name);
				errors++;
			end
			if (o_valid) begin
				if (exp_q.size() == 0) begin
					$display("ERROR %s: o_valid with no request outstanding", name);
					errors++;
				end else begin
					compare_word(name, exp_q.pop_front(), o_data);
					done++;
				end
			end
			cmp = i_req_valid && o_ready;
			if (cmp) begin
				last_pa = translate(vas[issued]);
				exp_q.push_back(mem_word(last_pa));
				issued++;
			end
			next_cycle();
		end
		i_req_valid = 1'b0;
	endtask

	task automatic sweep_then_first_miss();
		int    low_cycles;
		int    base;
		word_t q[$];
		low_cycles = 0;
		@(negedge i_clk);
		while (!o_ready && low_cycles < 4 * SETS) begin
			low_cycles++;
			@(negedge i_clk);
		end
		if (!o_ready) begin
			$display("ERROR reset sweep: o_ready never rose after reset");
			errors++;
		end else if (low_cycles < SETS) begin
			$display("ERROR reset sweep: o_ready rose after only %0d cycles", low_cycles);
			errors++;
		end
		next_cycle();
		base = mem_reqs;
		q.push_back(32'h0000_0000);
		run_fetches("first access", q, 1'b0);
		check_count("first access requests", base + 1, mem_reqs);
	endtask

	task automatic miss_then_line_hits();
		int    base;
		word_t q[$];
		base = mem_reqs;
		q.push_back(32'h0000_104c); // word 3 of its line
		run_fetches("miss restart", q, 1'b0);
		check_count("miss requests", base + 1, mem_reqs);
		compare_word("miss address", translate(32'h0000_104c), last_mem_addr);
		q.delete();
		for (int k = 0; k < WORDS; k++) begin
			if (k != 3) q.push_back(32'h0000_1040 + word_t'(4 * k));
		end
		run_fetches("line hits", q, 1'b1);
		check_count("line hit requests", base + 1, mem_reqs);
	endtask

	task automatic back_to_back_hits();
		int    base;
		word_t q[$];
		base = mem_reqs;
		for (int k = 0; k < WORDS; k++) begin
			q.push_back(32'h0000_0000 + word_t'(4 * k));
			q.push_back(32'h0000_1040 + word_t'(4 * (WORDS - 1 - k)));
		end
		run_fetches("back to back", q, 1'b1);
		check_count("back to back requests", base, mem_reqs);
	endtask

	task automatic critical_word_first();
		int    base;
		word_t q[$];
		base = mem_reqs;
		q.push_back(32'h0000_2094); // word 5
		run_fetches("critical word", q, 1'b0);
		check_count("critical word requests", base + 1, mem_reqs);
		compare_word("critical word address", translate(32'h0000_2094), last_mem_addr);
		q.delete();
		for (int k = 0; k < WORDS; k++) begin
			if (k != 5) q.push_back(32'h0000_2080 + word_t'(4 * k));
		end
		run_fetches("critical line hits", q, 1'b1);
		check_count("critical line requests", base + 1, mem_reqs);
	endtask

	task automatic plru_replacement();
		int    base;
		word_t q[$];
		base = mem_reqs;
		for (int n = 0; n < 5; n++) begin
			q.push_back(32'h0000_30a0 + word_t'(n * 32'h1000)); // A..E, all in set 5
		end
		run_fetches("fill set", q, 1'b0);
		check_count("fill set requests", base + 5, mem_reqs);
		q.delete();
		q.push_back(32'h0000_40a0);
		run_fetches("line B kept", q, 1'b1);
		check_count("line B requests", base + 5, mem_reqs);
		q.delete();
		q.push_back(32'h0000_30a0);
		run_fetches("line A evicted", q, 1'b0);
		check_count("line A requests", base + 6, mem_reqs);
	endtask

	initial begin
		i_rst = 1'b1;
		i_req_valid = 1'b0;
		i_va = '0;
		i_pa = '0;
		repeat (10) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		sweep_then_first_miss();
		miss_then_line_hits();
		back_to_back_hits();
		critical_word_first();
		plru_replacement();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- icache.f
icache_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_plru.sv
icache_lookup.sv
icache_refill.sv
icache.sv
icache_assert.sv
tb_icache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f icache.f

out=$(./obj_dir/Vtb_icache 2>&1) || true
echo "$out"

# exit status of grep decides pass or fail
echo "$out" | grep -q "All tests passed"
